//--- source/icache_macros.svh
// icache geometry constants shared by the package and the RTL
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// sets and ways
`define ICACHE_NUM_SETS           128
`define ICACHE_INDEX_WIDTH        7
`define ICACHE_NUM_WAYS           2

// physical block address is {tag, index}
`define ICACHE_TAG_WIDTH          22
`define ICACHE_BLOCK_ADDR_WIDTH   29

// block and fetch word sizes
`define ICACHE_FETCH_BYTES        16
`define ICACHE_FETCHES_PER_BLOCK  2
`define ICACHE_FETCH_OFFSET_WIDTH 1
`define ICACHE_BLOCK_BITS         256

`endif

//--- source/icache_pkg.sv
// icache package with the types shared across the cache datapath
`include "icache_macros.svh"

package icache_pkg;

    typedef logic [`ICACHE_INDEX_WIDTH-1:0]        index_t;
    typedef logic [`ICACHE_TAG_WIDTH-1:0]          tag_t;
    typedef logic [`ICACHE_FETCH_OFFSET_WIDTH-1:0] fetch_off_t;
    typedef logic [$clog2(`ICACHE_NUM_WAYS)-1:0]   way_t;
    typedef logic [`ICACHE_FETCH_BYTES*8-1:0]      fetch_word_t;

    // tag in the upper bits, index in the lower bits
    typedef logic [`ICACHE_BLOCK_ADDR_WIDTH-1:0]   block_addr_t;

    // fetch word 0 sits in the low half
    typedef logic [`ICACHE_BLOCK_BITS-1:0]         block_data_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } tag_entry_t;

    // data array row is {index, fetch offset}
    typedef logic [`ICACHE_INDEX_WIDTH+`ICACHE_FETCH_OFFSET_WIDTH-1:0] data_index_t;

    // pick one fetch word out of a full block
    function automatic fetch_word_t block_word(block_data_t blk, fetch_off_t off);
        return blk[off * $bits(fetch_word_t) +: $bits(fetch_word_t)];
    endfunction

endpackage

//--- source/way_bram.sv
// way_bram: two-way synchronous array, one registered read and a per-way write
`timescale 1ns/10ps
`include "icache_macros.svh"

module way_bram #(
    parameter type         ENTRY_T = logic [31:0],
    parameter int unsigned DEPTH   = 128
) (
    input  logic                              CLK,
    input  logic                              nRST,

    // read port, data valid the cycle after ren
    input  logic                              ren,
    input  logic [$clog2(DEPTH)-1:0]          rindex,
    output ENTRY_T [`ICACHE_NUM_WAYS-1:0]     rdata,

    // write port, one enable per way
    input  logic [`ICACHE_NUM_WAYS-1:0]       wen,
    input  logic [$clog2(DEPTH)-1:0]          windex,
    input  ENTRY_T                            wdata
);

    ENTRY_T [`ICACHE_NUM_WAYS-1:0] mem [DEPTH];

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            rdata <= '0;
        end else if (ren) begin
            rdata <= mem[rindex];
        end
    end

    // reset clears every row, so tag valid bits start at zero
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else begin
            for (int w = 0; w < `ICACHE_NUM_WAYS; w++) begin
                if (wen[w]) begin
                    mem[windex][w] <= wdata;
                end
            end
        end
    end

endmodule

//--- source/lru_state.sv
// lru_state: one LRU bit per set, written on core hit feedback
`timescale 1ns/10ps
`include "icache_macros.svh"

module lru_state (
    input  logic               CLK,
    input  logic               nRST,

    // hit feedback from the core
    input  logic               hit_valid,
    input  icache_pkg::way_t   hit_way,
    input  icache_pkg::index_t hit_index,

    // victim lookup for the miss handler
    input  icache_pkg::index_t victim_index,
    output icache_pkg::way_t   victim_way
);

    // bit set names the way to replace next
    logic [`ICACHE_NUM_SETS-1:0] lru_bits;

    assign victim_way = lru_bits[victim_index];

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            lru_bits <= '0;
        end else if (hit_valid) begin
            // way not hit becomes LRU
            lru_bits[hit_index] <= ~hit_way;
        end
    end

endmodule

//--- source/resp_stage.sv
// resp_stage: lookup register, array read addresses and per-way response with fill bypass
`timescale 1ns/10ps
`include "icache_macros.svh"

module resp_stage (
    input  logic                                               CLK,
    input  logic                                               nRST,

    // core request
    input  logic                                               core_req_valid,
    input  icache_pkg::index_t                                 core_req_index,
    input  icache_pkg::fetch_off_t                             core_req_offset,

    // array read ports
    output logic                                               tag_ren,
    output logic                                               data_ren,
    output icache_pkg::index_t                                 tag_rindex,
    output icache_pkg::data_index_t                            data_rindex,
    input  icache_pkg::tag_entry_t  [`ICACHE_NUM_WAYS-1:0]     tag_rdata,
    input  icache_pkg::fetch_word_t [`ICACHE_NUM_WAYS-1:0]     data_rdata,

    // fill state from the miss handler
    input  logic                                               bypass_active,
    input  icache_pkg::index_t                                 miss_index,
    input  icache_pkg::tag_t                                   miss_tag,
    input  icache_pkg::way_t                                   miss_way,
    input  icache_pkg::block_data_t                            miss_block,

    // response
    output icache_pkg::index_t                                 resp_index,
    output logic                                               index_match,
    output logic [`ICACHE_NUM_WAYS-1:0]                        valid_by_way,
    output icache_pkg::tag_t        [`ICACHE_NUM_WAYS-1:0]     tag_by_way,
    output icache_pkg::fetch_word_t [`ICACHE_NUM_WAYS-1:0]     instr_by_way
);

    import icache_pkg::*;

    logic       resp_valid;
    fetch_off_t resp_offset;

    // both arrays read straight from the request
    assign tag_ren     = core_req_valid;
    assign data_ren    = core_req_valid;
    assign tag_rindex  = core_req_index;
    assign data_rindex = {core_req_index, core_req_offset};

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            resp_valid  <= 1'b0;
            resp_index  <= '0;
            resp_offset <= '0;
        end else begin
            resp_valid  <= core_req_valid;
            resp_index  <= core_req_index;
            resp_offset <= core_req_offset;
        end
    end

    assign index_match = resp_valid && (resp_index == miss_index);

    // ------------------------------
    // per-way response
    // ------------------------------
    always_comb begin
        for (int w = 0; w < `ICACHE_NUM_WAYS; w++) begin
            valid_by_way[w] = tag_rdata[w].valid;
            tag_by_way[w]   = tag_rdata[w].tag;
            instr_by_way[w] = data_rdata[w];
        end

        // arrays may still be stale during the fill, take the buffered block
        if (bypass_active && index_match) begin
            valid_by_way[miss_way] = 1'b1;
            tag_by_way[miss_way]   = miss_tag;
            instr_by_way[miss_way] = block_word(miss_block, resp_offset);
        end
    end

endmodule

//--- source/miss_handler.sv
// miss_handler: single miss register, L2 request and response, fill of both arrays
`timescale 1ns/10ps
`include "icache_macros.svh"

module miss_handler (
    input  logic                               CLK,
    input  logic                               nRST,

    // miss feedback from the core
    input  logic                               miss_valid,
    input  icache_pkg::tag_t                   core_miss_tag,
    input  icache_pkg::index_t                 resp_index,
    input  logic                               index_match,
    input  icache_pkg::way_t                   victim_way,

    // L2 request
    output logic                               l2_req_valid,
    output icache_pkg::block_addr_t            l2_req_addr,
    input  logic                               l2_req_ready,

    // L2 response
    input  logic                               l2_resp_valid,
    input  icache_pkg::block_addr_t            l2_resp_addr,
    input  icache_pkg::block_data_t            l2_resp_data,

    // array writes
    output logic [`ICACHE_NUM_WAYS-1:0]        tag_wen,
    output logic [`ICACHE_NUM_WAYS-1:0]        data_wen,
    output icache_pkg::index_t                 tag_windex,
    output icache_pkg::data_index_t            data_windex,
    output icache_pkg::tag_entry_t             tag_wdata,
    output icache_pkg::fetch_word_t            data_wdata,

    // fill state for the response stage
    output logic                               bypass_active,
    output icache_pkg::index_t                 miss_index,
    output icache_pkg::tag_t                   miss_tag,
    output icache_pkg::way_t                   miss_way,
    output icache_pkg::block_data_t            miss_block
);

    import icache_pkg::*;

    localparam fetch_off_t LAST_OFF = fetch_off_t'(`ICACHE_FETCHES_PER_BLOCK - 1);

    // control part of the miss register
    logic        mreg_valid;
    logic        next_valid;
    logic        requested;
    logic        next_requested;
    logic        data_valid;
    logic        next_data_valid;
    fetch_off_t  fill_off;
    fetch_off_t  next_fill_off;
    logic        settle;
    logic        next_settle;

    // payload part
    index_t      next_index;
    tag_t        next_tag;
    way_t        next_way;
    block_data_t next_block;

    logic                         same_addr;
    logic                         resp_match;
    logic [`ICACHE_NUM_WAYS-1:0]  way_mask;

    assign l2_req_valid  = mreg_valid && !requested;
    assign l2_req_addr   = {miss_tag, miss_index};
    assign bypass_active = mreg_valid && (data_valid || settle);

    assign same_addr  = mreg_valid && index_match && (core_miss_tag == miss_tag);
    assign resp_match = l2_resp_valid && (l2_resp_addr == l2_req_addr);

    // ------------------------------
    // fill writes
    // ------------------------------
    assign way_mask    = `ICACHE_NUM_WAYS'(1) << miss_way;
    assign data_wen    = data_valid ? way_mask : '0;
    assign data_windex = {miss_index, fill_off};
    assign data_wdata  = block_word(miss_block, fill_off);

    // tag goes in with the last fetch word
    assign tag_wen    = (data_valid && (fill_off == LAST_OFF)) ? way_mask : '0;
    assign tag_windex = miss_index;
    assign tag_wdata  = '{valid: 1'b1, tag: miss_tag};

    // ------------------------------
    // next state
    // ------------------------------
    always_comb begin
        next_valid      = mreg_valid;
        next_requested  = requested;
        next_data_valid = data_valid;
        next_fill_off   = fill_off;
        next_settle     = 1'b0;
        next_index      = miss_index;
        next_tag        = miss_tag;
        next_way        = miss_way;
        next_block      = miss_block;

        if (data_valid) begin
            // one fetch word per cycle
            if (fill_off == LAST_OFF) begin
                next_data_valid = 1'b0;
                next_settle     = 1'b1;
            end else begin
                next_fill_off = fill_off + 1'b1;
            end
        end else if (miss_valid && !l2_req_valid && !same_addr) begin
            // new miss, an unaccepted L2 request keeps its address
            next_valid     = 1'b1;
            next_requested = 1'b0;
            next_fill_off  = '0;
            next_index     = resp_index;
            next_tag       = core_miss_tag;
            next_way       = victim_way;
        end else if (settle) begin
            next_valid = 1'b0;
        end else if (mreg_valid) begin
            if (resp_match) begin
                // response can beat the ready, so it also closes the request
                next_requested  = 1'b1;
                next_data_valid = 1'b1;
                next_fill_off   = '0;
                next_block      = l2_resp_data;
            end else if (!requested && l2_req_ready) begin
                next_requested = 1'b1;
            end
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            mreg_valid <= 1'b0;
            requested  <= 1'b0;
            data_valid <= 1'b0;
            fill_off   <= '0;
            settle     <= 1'b0;
        end else begin
            mreg_valid <= next_valid;
            requested  <= next_requested;
            data_valid <= next_data_valid;
            fill_off   <= next_fill_off;
            settle     <= next_settle;
        end
    end

    always_ff @(posedge CLK) begin
        miss_index <= next_index;
        miss_tag   <= next_tag;
        miss_way   <= next_way;
        miss_block <= next_block;
    end

endmodule

//--- source/icache.sv
// icache: blocking two-way set-associative L1 instruction cache top level
`timescale 1ns/10ps
`include "icache_macros.svh"

module icache (
    input  logic                                               CLK,
    input  logic                                               nRST,

    // core request, cannot be stalled
    input  logic                                               core_req_valid,
    input  icache_pkg::index_t                                 core_req_index,
    input  icache_pkg::fetch_off_t                             core_req_offset,

    // core response
    output logic [`ICACHE_NUM_WAYS-1:0]                        valid_by_way,
    output icache_pkg::tag_t        [`ICACHE_NUM_WAYS-1:0]     tag_by_way,
    output icache_pkg::fetch_word_t [`ICACHE_NUM_WAYS-1:0]     instr_by_way,

    // core feedback, same cycle as the response
    input  logic                                               hit_valid,
    input  icache_pkg::way_t                                   hit_way,
    input  logic                                               miss_valid,
    input  icache_pkg::tag_t                                   miss_tag,

    // L2 request
    output logic                                               l2_req_valid,
    output icache_pkg::block_addr_t                            l2_req_addr,
    input  logic                                               l2_req_ready,

    // L2 response, cannot be stalled
    input  logic                                               l2_resp_valid,
    input  icache_pkg::block_addr_t                            l2_resp_addr,
    input  icache_pkg::block_data_t                            l2_resp_data
);

    import icache_pkg::*;

    // ------------------------------
    // array ports
    // ------------------------------
    logic                                   tag_ren;
    index_t                                 tag_rindex;
    tag_entry_t  [`ICACHE_NUM_WAYS-1:0]     tag_rdata;
    logic        [`ICACHE_NUM_WAYS-1:0]     tag_wen;
    index_t                                 tag_windex;
    tag_entry_t                             tag_wdata;

    logic                                   data_ren;
    data_index_t                            data_rindex;
    fetch_word_t [`ICACHE_NUM_WAYS-1:0]     data_rdata;
    logic        [`ICACHE_NUM_WAYS-1:0]     data_wen;
    data_index_t                            data_windex;
    fetch_word_t                            data_wdata;

    // response stage and miss register
    index_t      resp_index;
    logic        index_match;
    way_t        victim_way;
    logic        bypass_active;
    index_t      miss_index;
    tag_t        fill_tag;
    way_t        miss_way;
    block_data_t miss_block;

    way_bram #(
        .ENTRY_T (tag_entry_t),
        .DEPTH   (`ICACHE_NUM_SETS)
    ) u_tag_array (
        .CLK    (CLK),
        .nRST   (nRST),
        .ren    (tag_ren),
        .rindex (tag_rindex),
        .rdata  (tag_rdata),
        .wen    (tag_wen),
        .windex (tag_windex),
        .wdata  (tag_wdata)
    );

    way_bram #(
        .ENTRY_T (fetch_word_t),
        .DEPTH   (`ICACHE_NUM_SETS * `ICACHE_FETCHES_PER_BLOCK)
    ) u_data_array (
        .CLK    (CLK),
        .nRST   (nRST),
        .ren    (data_ren),
        .rindex (data_rindex),
        .rdata  (data_rdata),
        .wen    (data_wen),
        .windex (data_windex),
        .wdata  (data_wdata)
    );

    lru_state u_lru_state (
        .CLK          (CLK),
        .nRST         (nRST),
        .hit_valid    (hit_valid),
        .hit_way      (hit_way),
        .hit_index    (resp_index),
        .victim_index (resp_index),
        .victim_way   (victim_way)
    );

    resp_stage u_resp_stage (
        .CLK             (CLK),
        .nRST            (nRST),
        .core_req_valid  (core_req_valid),
        .core_req_index  (core_req_index),
        .core_req_offset (core_req_offset),
        .tag_ren         (tag_ren),
        .data_ren        (data_ren),
        .tag_rindex      (tag_rindex),
        .data_rindex     (data_rindex),
        .tag_rdata       (tag_rdata),
        .data_rdata      (data_rdata),
        .bypass_active   (bypass_active),
        .miss_index      (miss_index),
        .miss_tag        (fill_tag),
        .miss_way        (miss_way),
        .miss_block      (miss_block),
        .resp_index      (resp_index),
        .index_match     (index_match),
        .valid_by_way    (valid_by_way),
        .tag_by_way      (tag_by_way),
        .instr_by_way    (instr_by_way)
    );

    miss_handler u_miss_handler (
        .CLK           (CLK),
        .nRST          (nRST),
        .miss_valid    (miss_valid),
        .core_miss_tag (miss_tag),
        .resp_index    (resp_index),
        .index_match   (index_match),
        .victim_way    (victim_way),
        .l2_req_valid  (l2_req_valid),
        .l2_req_addr   (l2_req_addr),
        .l2_req_ready  (l2_req_ready),
        .l2_resp_valid (l2_resp_valid),
        .l2_resp_addr  (l2_resp_addr),
        .l2_resp_data  (l2_resp_data),
        .tag_wen       (tag_wen),
        .data_wen      (data_wen),
        .tag_windex    (tag_windex),
        .data_windex   (data_windex),
        .tag_wdata     (tag_wdata),
        .data_wdata    (data_wdata),
        .bypass_active (bypass_active),
        .miss_index    (miss_index),
        .miss_tag      (fill_tag),
        .miss_way      (miss_way),
        .miss_block    (miss_block)
    );

endmodule

//--- testbench/icache_props.sv
// icache_props: assertions on the L2 request handshake and the core response valids
`timescale 1ns/10ps
`include "icache_macros.svh"

module icache_props (
    input  logic                           CLK,
    input  logic                           nRST,
    input  logic                           l2_req_valid,
    input  logic                           l2_req_ready,
    input  icache_pkg::block_addr_t        l2_req_addr,
    input  logic [`ICACHE_NUM_WAYS-1:0]    valid_by_way
);

    // ------------------------------
    // L2 request handshake
    // ------------------------------

    // a waiting request keeps its valid
    a_req_held: assert property (@(posedge CLK) disable iff (!nRST)
        (l2_req_valid && !l2_req_ready) |=> l2_req_valid)
        else $error("l2_req_valid dropped while the request was waiting for ready");

    // and keeps its address
    a_addr_stable: assert property (@(posedge CLK) disable iff (!nRST)
        (l2_req_valid && !l2_req_ready) |=> $stable(l2_req_addr))
        else $error("l2_req_addr changed while the request was waiting for ready");

    // ------------------------------
    // core response
    // ------------------------------
    a_valid_known: assert property (@(posedge CLK) disable iff (!nRST)
        !$isunknown(valid_by_way))
        else $error("valid_by_way is unknown after reset");

endmodule

//--- testbench/tb_icache.sv
// tb_icache checks random lookups against a cache model and acts as the L2
`timescale 1ns/10ps
`include "icache_macros.svh"

module tb_icache;

    import icache_pkg::*;

    localparam logic [31:0] SEED        = 32'hdf4f_4281;
    localparam int          NUM_COLD    = 16;
    localparam int          NUM_OPS     = 300;
    // 20 cycles of 100 ns per operation and one spare for reset
    localparam longint      WATCHDOG_NS = longint'(NUM_COLD + NUM_OPS + 1) * 20 * 100;

    logic                                   CLK;
    logic                                   nRST;
    logic                                   core_req_valid;
    index_t                                 core_req_index;
    fetch_off_t                             core_req_offset;
    logic        [`ICACHE_NUM_WAYS-1:0]     valid_by_way;
    tag_t        [`ICACHE_NUM_WAYS-1:0]     tag_by_way;
    fetch_word_t [`ICACHE_NUM_WAYS-1:0]     instr_by_way;
    logic                                   hit_valid;
    way_t                                   hit_way;
    logic                                   miss_valid;
    tag_t                                   miss_tag;
    logic                                   l2_req_valid;
    block_addr_t                            l2_req_addr;
    logic                                   l2_req_ready;
    logic                                   l2_resp_valid;
    block_addr_t                            l2_resp_addr;
    block_data_t                            l2_resp_data;

    // small pools so that sets fill up and get evicted
    index_t index_pool [4] = '{7'h05, 7'h2a, 7'h40, 7'h7f};
    tag_t   tag_pool   [4] = '{22'h01_2345, 22'h2b_cdef, 22'h3f_0001, 22'h10_0a0a};

    // cache model
    logic [`ICACHE_NUM_WAYS-1:0] model_valid [`ICACHE_NUM_SETS] = '{default: '0};
    tag_t   model_tag [`ICACHE_NUM_SETS][`ICACHE_NUM_WAYS] = '{default: '0};
    way_t   model_lru [`ICACHE_NUM_SETS] = '{default: '0};

    logic [31:0] rng_state;

    icache u_icache (.*);

    bind icache icache_props u_icache_props (
        .CLK          (CLK),
        .nRST         (nRST),
        .l2_req_valid (l2_req_valid),
        .l2_req_ready (l2_req_ready),
        .l2_req_addr  (l2_req_addr),
        .valid_by_way (valid_by_way)
    );

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    initial begin
        #(WATCHDOG_NS);
        report_fail("watchdog expired before the tests finished");
    end

    // ------------------------------
    // helpers
    // ------------------------------
    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // L2 block contents built from eight xorshift words of the address
    function automatic block_data_t make_block(block_addr_t addr);
        logic [31:0] x;
        block_data_t blk;
        x   = {3'b000, addr} ^ 32'h9e37_79b9;
        blk = '0;
        for (int i = 0; i < 8; i++) begin
            x   = xorshift32(x);
            blk = {x, blk[255:32]};
        end
        return blk;
    endfunction

    task automatic report_fail(string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_valid(string name, logic [`ICACHE_NUM_WAYS-1:0] exp,
                               logic [`ICACHE_NUM_WAYS-1:0] act);
        if (act !== exp) begin
            report_fail($sformatf("** Error: %s valid expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic check_tag(string name, tag_t exp, tag_t act);
        if (act !== exp) begin
            report_fail($sformatf("** Error: %s tag expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_word(string name, fetch_word_t exp, fetch_word_t act);
        if (act !== exp) begin
            report_fail($sformatf("** Error: %s word expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_addr(string name, block_addr_t exp, block_addr_t act);
        if (act !== exp) begin
            report_fail($sformatf("** Error: %s addr expected %h actual %h", name, exp, act));
        end
    endtask

    // inputs change 1 ns after the rising edge
    task automatic step();
        @(posedge CLK);
        #1;
    endtask

    task automatic check_way(string name, index_t idx, fetch_off_t off, way_t w);
        block_data_t blk;
        fetch_word_t exp_word;
        if (model_valid[idx][w]) begin
            blk      = make_block({model_tag[idx][w], idx});
            exp_word = (off == 1'b1) ? blk[255:128] : blk[127:0];
            check_tag(name, model_tag[idx][w], tag_by_way[w]);
            check_word(name, exp_word, instr_by_way[w]);
        end
    endtask

    task automatic check_response(string name, index_t idx, fetch_off_t off);
        check_valid(name, model_valid[idx], valid_by_way);
        check_way(name, idx, off, 1'b0);
        check_way(name, idx, off, 1'b1);
    endtask

    // ------------------------------
    // L2 request, response and fill
    // ------------------------------
    task automatic run_fill(index_t idx, tag_t tag, way_t victim);
        block_addr_t addr;
        int          delay;
        fetch_off_t  off;
        addr = {tag, idx};
        if (!l2_req_valid) begin
            report_fail("l2_req_valid did not rise in the cycle after the miss");
        end
        check_addr("l2_req", addr, l2_req_addr);
        rng_state = xorshift32(rng_state);
        delay     = int'(rng_state[1:0]);
        repeat (delay) begin
            step();
            if (!l2_req_valid) begin
                report_fail("l2_req_valid dropped before ready was given");
            end
            check_addr("l2_req_hold", addr, l2_req_addr);
        end
        l2_req_ready = 1'b1;
        step();
        l2_req_ready = 1'b0;
        if (l2_req_valid) begin
            report_fail("l2_req_valid still high after the request was accepted");
        end

        // a response for another block must be ignored
        if (rng_state[2]) begin
            l2_resp_valid   = 1'b1;
            l2_resp_addr    = {~tag, idx};
            l2_resp_data    = make_block({~tag, idx});
            core_req_valid  = 1'b1;
            core_req_index  = idx;
            core_req_offset = rng_state[3];
            step();
            l2_resp_valid  = 1'b0;
            core_req_valid = 1'b0;
            check_response("l2_wrong_addr", idx, rng_state[3]);
        end

        // matching response in cycle R makes the new block visible from R+1
        l2_resp_valid  = 1'b1;
        l2_resp_addr   = addr;
        l2_resp_data   = make_block(addr);
        model_valid[idx][victim] = 1'b1;
        model_tag[idx][victim]   = tag;
        off             = 1'b0;
        core_req_valid  = 1'b1;
        core_req_index  = idx;
        core_req_offset = off;
        repeat (5) begin
            step();
            l2_resp_valid = 1'b0;
            check_response("fill", idx, off);
            off             = ~off;
            core_req_offset = off;
        end
        core_req_valid = 1'b0;
    endtask

    // one lookup with hit or miss feedback
    task automatic run_op();
        index_t     idx;
        tag_t       want;
        fetch_off_t off;
        way_t       hw;
        logic       hit;
        rng_state       = xorshift32(rng_state);
        idx             = index_pool[rng_state[1:0]];
        want            = tag_pool[rng_state[3:2]];
        off             = rng_state[4];
        core_req_valid  = 1'b1;
        core_req_index  = idx;
        core_req_offset = off;
        step();
        core_req_valid = 1'b0;
        check_response("lookup", idx, off);

        hit = 1'b1;
        hw  = 1'b0;
        if (valid_by_way[0] && (tag_by_way[0] == want)) begin
            hw = 1'b0;
        end else if (valid_by_way[1] && (tag_by_way[1] == want)) begin
            hw = 1'b1;
        end else begin
            hit = 1'b0;
        end

        if (hit) begin
            hit_valid      = 1'b1;
            hit_way        = hw;
            model_lru[idx] = ~hw;
            step();
            hit_valid = 1'b0;
        end else begin
            miss_valid = 1'b1;
            miss_tag   = want;
            step();
            miss_valid = 1'b0;
            run_fill(idx, want, model_lru[idx]);
        end
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        rng_state       = SEED;
        nRST            = 1'b0;
        core_req_valid  = 1'b0;
        core_req_index  = '0;
        core_req_offset = '0;
        hit_valid       = 1'b0;
        hit_way         = '0;
        miss_valid      = 1'b0;
        miss_tag        = '0;
        l2_req_ready    = 1'b0;
        l2_resp_valid   = 1'b0;
        l2_resp_addr    = '0;
        l2_resp_data    = '0;

        repeat (10) @(posedge CLK);
        #1;
        nRST = 1'b1;

        // cold cache shows every way invalid and no L2 traffic
        repeat (NUM_COLD) begin
            rng_state       = xorshift32(rng_state);
            core_req_valid  = 1'b1;
            core_req_index  = rng_state[6:0];
            core_req_offset = rng_state[7];
            step();
            core_req_valid = 1'b0;
            check_valid("cold", '0, valid_by_way);
            if (l2_req_valid) begin
                report_fail("l2_req_valid high without any miss");
            end
        end

        repeat (NUM_OPS) begin
            run_op();
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+source
source/icache_pkg.sv
source/way_bram.sv
source/lru_state.sv
source/resp_stage.sv
source/miss_handler.sv
source/icache.sv
testbench/icache_props.sv
testbench/tb_icache.sv

//--- run_sim.sh
#!/bin/sh
# build the icache testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f vlog.f --top-module tb_icache -o sim_icache

# the log decides the result, so a failing run must not stop the script here
status=0
./obj_dir/sim_icache > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
if [ "$status" -ne 0 ]; then
    exit 1
fi
exit 0
